// File: vecParams.svh
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

////////////////////////////////////////////////////////////
// Datapath widths

`define DATA_W			32		// Lane data word
`define ADDR_W			12		// Memory word address
`define REG_W			5		// Destination register index
`define ISSUE_W			4		// Issue number, wraps around

////////////////////////////////////////////////////////////
// Depths and credits

`define LANE_CREDITS	4		// Issue credits and unit queue depth
`define WB_CREDITS		2		// Write-back credits from the register file
`define MAU_DEPTH		3		// Multiply-add latency, at least 2

`endif

// File: vecIsaPkg.sv
`include "vecParams.svh"

package vecIsaPkg;

	////////////////////////////////////////////////////////////
	// Opcodes seen by the lane

	typedef enum logic [2:0] {
		OP_NOP		= 3'd0,			// Dropped at the lane input
		OP_MULADD	= 3'd1,
		OP_MOVE		= 3'd2,
		OP_LOAD		= 3'd3,
		OP_STORE	= 3'd4
	} opcodeT;

	////////////////////////////////////////////////////////////
	// Decoded command with its operands

	typedef struct packed {
		opcodeT					op;
		logic [`REG_W-1:0]		dst;		// Destination register
		logic [`DATA_W-1:0]		srcA;		// Also store data and move data
		logic [`DATA_W-1:0]		srcB;
		logic [`DATA_W-1:0]		srcC;		// Addend
		logic [`ADDR_W-1:0]		addr;		// Load/store word address
	} commandT;

endpackage

// File: vecLanePkg.sv
`include "vecParams.svh"

package vecLanePkg;

	////////////////////////////////////////////////////////////
	// Finished result waiting for in-order commit

	typedef struct packed {
		logic [`ISSUE_W-1:0]	issueNo;	// Commit order tag
		logic [`REG_W-1:0]		dst;
		logic [`DATA_W-1:0]		data;
		logic					write;		// Low for stores
	} resultT;

	////////////////////////////////////////////////////////////
	// Load/store memory port sequencing

	typedef enum logic [1:0] {
		LS_IDLE	= 2'd0,
		LS_REQ	= 2'd1,				// Request held until grant
		LS_WAIT	= 2'd2				// Waiting for read/ack data
	} ldStStateT;

endpackage

// File: resultIf.sv
`timescale 1ns/1ps

interface resultIf;
	import vecLanePkg::*;

	logic		valid;				// Unit queue head present
	logic		ack;				// One-cycle pop from the arbiter
	resultT		result;				// Head entry

	// Unit side presents its queue head
	modport unit (
		output	valid,
		output	result,
		input	ack
	);

	// Arbiter side pops the head on commit
	modport arb (
		input	valid,
		input	result,
		output	ack
	);

endinterface

// File: mulAddUnit.sv
`timescale 1ns/1ps
`include "vecParams.svh"

module mulAddUnit (
	input	logic						clock,
	input	logic						arstN,
	input	logic						req,			// Multiply-add accepted
	input	vecIsaPkg::commandT			cmd,
	input	logic [`ISSUE_W-1:0]		issueNo,
	resultIf.unit						res
);
	import vecLanePkg::*;

	localparam int DEPTH	= `MAU_DEPTH;
	localparam int QDEPTH	= `LANE_CREDITS;
	localparam int PTR_W	= (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

	logic						stgValid	[DEPTH];
	resultT						stg			[DEPTH];
	logic [`DATA_W-1:0]			addendC;					// srcC for the add stage
	resultT						sumStage;

	resultT						queue		[QDEPTH];
	logic [PTR_W-1:0]			wrPtr;
	logic [PTR_W-1:0]			rdPtr;
	logic [PTR_W:0]				count;
	logic						push;
	logic						pop;

	////////////////////////////////////////////////////////////
	// Pipeline, multiply in stage 0 and add in stage 1

	always_comb begin
		sumStage		= stg[0];
		sumStage.data	= stg[0].data + addendC;			// Truncated to DATA_W
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < DEPTH; i++) begin
				stgValid[i] <= 1'b0;
			end
		end else begin
			stgValid[0] <= req;
			for (int i = 1; i < DEPTH; i++) begin
				stgValid[i] <= stgValid[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		stg[0].issueNo	<= issueNo;
		stg[0].dst		<= cmd.dst;
		stg[0].data		<= cmd.srcA * cmd.srcB;				// Low half of product
		stg[0].write	<= 1'b1;
		addendC			<= cmd.srcC;
		stg[1]			<= sumStage;
		for (int i = 2; i < DEPTH; i++) begin
			stg[i] <= stg[i-1];
		end
	end

	////////////////////////////////////////////////////////////
	// Result queue

	assign push			= stgValid[DEPTH-1];
	assign pop			= res.ack;
	assign res.valid	= (count != '0);
	assign res.result	= queue[rdPtr];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == PTR_W'(QDEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PTR_W'(QDEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			queue[wrPtr] <= stg[DEPTH-1];
		end
	end

	// Issue credits at the dispatcher keep this queue from filling
	assert property (@(posedge clock) disable iff (!arstN)
		push |-> (count < QDEPTH) || pop)
		else $error("mulAddUnit queue pushed while full");

endmodule

// File: moveBuffer.sv
`timescale 1ns/1ps
`include "vecParams.svh"

module moveBuffer (
	input	logic						clock,
	input	logic						arstN,
	input	logic						req,			// Register move accepted
	input	vecIsaPkg::commandT			cmd,
	input	logic [`ISSUE_W-1:0]		issueNo,
	resultIf.unit						res
);
	import vecLanePkg::*;

	localparam int QDEPTH	= `LANE_CREDITS;
	localparam int PTR_W	= (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

	resultT						ring		[QDEPTH];
	logic [PTR_W-1:0]			wrPtr;
	logic [PTR_W-1:0]			rdPtr;
	logic [PTR_W:0]				count;

	assign res.valid	= (count != '0);				// Valid the cycle after push
	assign res.result	= ring[rdPtr];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end else begin
			if (req) begin
				wrPtr <= (wrPtr == PTR_W'(QDEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (res.ack) begin
				rdPtr <= (rdPtr == PTR_W'(QDEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			count <= count + (PTR_W + 1)'(req) - (PTR_W + 1)'(res.ack);
		end
	end

	always_ff @(posedge clock) begin
		if (req) begin
			ring[wrPtr] <= '{issueNo: issueNo, dst: cmd.dst, data: cmd.srcA, write: 1'b1};
		end
	end

	// Overflow means the dispatcher ignored its credit count
	assert property (@(posedge clock) disable iff (!arstN)
		req |-> (count < QDEPTH) || res.ack)
		else $error("moveBuffer overflow");

endmodule

// File: ldStUnit.sv
`timescale 1ns/1ps
`include "vecParams.svh"

module ldStUnit (
	input	logic						clock,
	input	logic						arstN,
	input	logic						req,			// Load or store for this port
	input	vecIsaPkg::commandT			cmd,
	input	logic [`ISSUE_W-1:0]		issueNo,
	resultIf.unit						res,
	output	logic						memReq,
	output	logic						memWe,
	output	logic [`ADDR_W-1:0]			memAddr,
	output	logic [`DATA_W-1:0]			memWdata,
	input	logic						memGnt,
	input	logic						memRvalid,		// Read data or write ack
	input	logic [`DATA_W-1:0]			memRdata
);
	import vecIsaPkg::*;
	import vecLanePkg::*;

	localparam int QDEPTH	= `LANE_CREDITS;
	localparam int PTR_W	= (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

	commandT					qCmd		[QDEPTH];
	logic [`ISSUE_W-1:0]		qIssue		[QDEPTH];
	logic [PTR_W-1:0]			wrPtr;
	logic [PTR_W-1:0]			rdPtr;
	logic [PTR_W:0]				count;

	ldStStateT					state;
	commandT					curCmd;					// Access in progress
	logic [`ISSUE_W-1:0]		curIssue;
	logic						isStore;
	logic						start;
	logic						done;
	logic						resValid;
	resultT						resReg;

	////////////////////////////////////////////////////////////
	// Command queue

	assign start = (state == LS_IDLE) && (count != '0) && !resValid;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end else begin
			if (req) begin
				wrPtr <= (wrPtr == PTR_W'(QDEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (start) begin
				rdPtr <= (rdPtr == PTR_W'(QDEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			count <= count + (PTR_W + 1)'(req) - (PTR_W + 1)'(start);
		end
	end

	always_ff @(posedge clock) begin
		if (req) begin
			qCmd[wrPtr]		<= cmd;
			qIssue[wrPtr]	<= issueNo;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory port FSM

	assign isStore	= (curCmd.op == OP_STORE);
	assign done		= (state == LS_WAIT) && memRvalid;
	assign memReq	= (state == LS_REQ);
	assign memWe	= isStore;
	assign memAddr	= curCmd.addr;
	assign memWdata	= curCmd.srcA;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state		<= LS_IDLE;
			resValid	<= 1'b0;
		end else begin
			case (state)
				LS_IDLE:	state <= start ? LS_REQ : LS_IDLE;
				LS_REQ:		state <= memGnt ? LS_WAIT : LS_REQ;
				LS_WAIT:	state <= memRvalid ? LS_IDLE : LS_WAIT;
				default:	state <= LS_IDLE;
			endcase
			if (done) begin
				resValid <= 1'b1;
			end else if (res.ack) begin
				resValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			curCmd		<= qCmd[rdPtr];
			curIssue	<= qIssue[rdPtr];
		end
		if (done) begin
			resReg.issueNo	<= curIssue;
			resReg.dst		<= curCmd.dst;
			resReg.data		<= isStore ? curCmd.srcA : memRdata;	// Store echoes its data
			resReg.write	<= !isStore;
		end
	end

	assign res.valid	= resValid;
	assign res.result	= resReg;

	// Memory answers only an access that it has granted
	assert property (@(posedge clock) disable iff (!arstN)
		memRvalid |-> (state == LS_WAIT))
		else $error("ldStUnit memory response with no access pending");

endmodule

// File: wbArbiter.sv
`timescale 1ns/1ps
`include "vecParams.svh"

module wbArbiter (
	input	logic						clock,
	input	logic						arstN,
	resultIf.arb						mau,
	resultIf.arb						mov,
	resultIf.arb						lsEven,
	resultIf.arb						lsOdd,
	input	logic						wbCredit,		// Credit return pulse
	output	logic						wbValid,
	output	logic						wbWrite,
	output	logic [`REG_W-1:0]			wbDst,
	output	logic [`DATA_W-1:0]			wbData,
	output	logic [`ISSUE_W-1:0]		wbIssueNo,
	output	logic						cmdCredit		// Issue credit back to dispatcher
);
	import vecLanePkg::*;

	localparam int CNT_W = $clog2(`WB_CREDITS + 1);

	logic [`ISSUE_W-1:0]		expNo;					// Next issue number to commit
	logic [CNT_W-1:0]			wbCnt;
	logic [3:0]					hit;
	logic						go;
	resultT						sel;

	assign hit[0]	= mau.valid && (mau.result.issueNo == expNo);
	assign hit[1]	= mov.valid && (mov.result.issueNo == expNo);
	assign hit[2]	= lsEven.valid && (lsEven.result.issueNo == expNo);
	assign hit[3]	= lsOdd.valid && (lsOdd.result.issueNo == expNo);
	assign go		= (|hit) && (wbCnt != '0);

	assign mau.ack		= go && hit[0];
	assign mov.ack		= go && hit[1];
	assign lsEven.ack	= go && hit[2];
	assign lsOdd.ack	= go && hit[3];

	// Issue numbers in flight are unique, so at most one hit
	always_comb begin
		sel = mau.result;
		if (hit[1]) sel = mov.result;
		if (hit[2]) sel = lsEven.result;
		if (hit[3]) sel = lsOdd.result;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			expNo		<= '0;
			wbCnt		<= CNT_W'(`WB_CREDITS);
			wbValid		<= 1'b0;
			cmdCredit	<= 1'b0;
		end else begin
			wbValid		<= go;
			cmdCredit	<= go;
			if (go) expNo <= expNo + 1'b1;
			wbCnt <= wbCnt - CNT_W'(go) + CNT_W'(wbCredit);
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			wbWrite		<= sel.write;
			wbDst		<= sel.dst;
			wbData		<= sel.data;
			wbIssueNo	<= sel.issueNo;
		end
	end

	// Two units never hold the same issue number
	assert property (@(posedge clock) disable iff (!arstN)
		$onehot0(hit))
		else $error("More than one unit holds the expected issue number");

	// Register file returns no more credits than write-backs sent
	assert property (@(posedge clock) disable iff (!arstN)
		wbCredit |-> wbCnt < `WB_CREDITS)
		else $error("Write-back credit returned in excess");

endmodule

// File: execLane.sv
`timescale 1ns/1ps
`include "vecParams.svh"

module execLane (
	input	logic						clock,
	input	logic						arstN,
	input	logic						cmdValid,
	input	vecIsaPkg::opcodeT			cmdOp,
	input	logic [`REG_W-1:0]			cmdDst,
	input	logic [`DATA_W-1:0]			cmdSrcA,
	input	logic [`DATA_W-1:0]			cmdSrcB,
	input	logic [`DATA_W-1:0]			cmdSrcC,
	input	logic [`ADDR_W-1:0]			cmdAddr,
	input	logic						memGnt		[2],	// Index 0 even, 1 odd
	input	logic						memRvalid	[2],
	input	logic [`DATA_W-1:0]			memRdata	[2],
	input	logic						wbCredit,
	output	logic						cmdCredit,
	output	logic						memReq		[2],
	output	logic						memWe		[2],
	output	logic [`ADDR_W-1:0]			memAddr		[2],
	output	logic [`DATA_W-1:0]			memWdata	[2],
	output	logic						wbValid,
	output	logic						wbWrite,
	output	logic [`REG_W-1:0]			wbDst,
	output	logic [`DATA_W-1:0]			wbData,
	output	logic [`ISSUE_W-1:0]		wbIssueNo
);
	import vecIsaPkg::*;

	commandT					cmd;
	logic [`ISSUE_W-1:0]		issueNo;				// Tag for the current command
	logic						isLdSt;
	logic						mauReq;
	logic						movReq;
	logic						lsReq		[2];

	resultIf mauRes ();
	resultIf movRes ();
	resultIf lsEvenRes ();
	resultIf lsOddRes ();

	////////////////////////////////////////////////////////////
	// Issue numbering and routing

	assign cmd = '{op: cmdOp, dst: cmdDst, srcA: cmdSrcA, srcB: cmdSrcB,
					srcC: cmdSrcC, addr: cmdAddr};

	assign isLdSt		= (cmdOp == OP_LOAD) || (cmdOp == OP_STORE);
	assign mauReq		= cmdValid && (cmdOp == OP_MULADD);
	assign movReq		= cmdValid && (cmdOp == OP_MOVE);
	assign lsReq[0]		= cmdValid && isLdSt && !cmdAddr[0];
	assign lsReq[1]		= cmdValid && isLdSt && cmdAddr[0];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			issueNo <= '0;
		end else if (cmdValid && (cmdOp != OP_NOP)) begin
			issueNo <= issueNo + 1'b1;				// NOP takes no number
		end
	end

	////////////////////////////////////////////////////////////
	// Units

	mulAddUnit mau (
		.clock(clock), .arstN(arstN), .req(mauReq), .cmd(cmd),
		.issueNo(issueNo), .res(mauRes.unit)
	);

	moveBuffer mov (
		.clock(clock), .arstN(arstN), .req(movReq), .cmd(cmd),
		.issueNo(issueNo), .res(movRes.unit)
	);

	ldStUnit ldStEven (
		.clock(clock), .arstN(arstN), .req(lsReq[0]), .cmd(cmd),
		.issueNo(issueNo), .res(lsEvenRes.unit),
		.memReq(memReq[0]), .memWe(memWe[0]), .memAddr(memAddr[0]),
		.memWdata(memWdata[0]), .memGnt(memGnt[0]), .memRvalid(memRvalid[0]),
		.memRdata(memRdata[0])
	);

	ldStUnit ldStOdd (
		.clock(clock), .arstN(arstN), .req(lsReq[1]), .cmd(cmd),
		.issueNo(issueNo), .res(lsOddRes.unit),
		.memReq(memReq[1]), .memWe(memWe[1]), .memAddr(memAddr[1]),
		.memWdata(memWdata[1]), .memGnt(memGnt[1]), .memRvalid(memRvalid[1]),
		.memRdata(memRdata[1])
	);

	wbArbiter arbiter (
		.clock(clock), .arstN(arstN),
		.mau(mauRes.arb), .mov(movRes.arb), .lsEven(lsEvenRes.arb), .lsOdd(lsOddRes.arb),
		.wbCredit(wbCredit), .wbValid(wbValid), .wbWrite(wbWrite), .wbDst(wbDst),
		.wbData(wbData), .wbIssueNo(wbIssueNo), .cmdCredit(cmdCredit)
	);

endmodule

// File: execLaneTb.sv
`timescale 1ns/1ps
`include "vecParams.svh"

module execLaneTb;
	import vecIsaPkg::*;
	import vecLanePkg::*;

	localparam int TIMEOUT	= 300;							// Cycles per wait loop
	localparam int MEM_SIZE	= 1 << `ADDR_W;

	logic					clock = 1'b0;
	logic					arstN;
	logic					cmdValid;
	opcodeT					cmdOp;
	logic [`REG_W-1:0]		cmdDst;
	logic [`DATA_W-1:0]		cmdSrcA;
	logic [`DATA_W-1:0]		cmdSrcB;
	logic [`DATA_W-1:0]		cmdSrcC;
	logic [`ADDR_W-1:0]		cmdAddr;
	logic					memGnt		[2] = '{1'b0, 1'b0};
	logic					memRvalid	[2] = '{1'b0, 1'b0};
	logic [`DATA_W-1:0]		memRdata	[2] = '{'0, '0};
	logic					wbCredit = 1'b0;
	logic					cmdCredit;
	logic					memReq		[2];
	logic					memWe		[2];
	logic [`ADDR_W-1:0]		memAddr		[2];
	logic [`DATA_W-1:0]		memWdata	[2];
	logic					wbValid;
	logic					wbWrite;
	logic [`REG_W-1:0]		wbDst;
	logic [`DATA_W-1:0]		wbData;
	logic [`ISSUE_W-1:0]	wbIssueNo;

	integer					seed = 32'h7bbd;
	integer					creditSeed;
	commandT				rows		[$];					// Stimulus table
	resultT					expQ		[$];					// Expected write-backs in issue order
	logic [`DATA_W-1:0]		memory		[2][MEM_SIZE];			// Index 0 even port, 1 odd port
	logic [`DATA_W-1:0]		shadow		[MEM_SIZE];
	int						errors = 0;
	int						commits = 0;
	int						expCount = 0;
	int						inFlight = 0;
	int						uncredited = 0;
	int						creditWait = 0;
	bit						timedOut = 1'b0;

	execLane UUT (.*);

	always #2 clock = ~clock;

	function automatic logic [`DATA_W-1:0] fillWord(input int a);
		return 32'h5A00_0000 ^ (a * 32'h0001_0003);
	endfunction

	task checkValue(input string name, input logic [`DATA_W-1:0] got,
			input logic [`DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task addRow(input opcodeT op, input int dst, input logic [`DATA_W-1:0] a,
			input logic [`DATA_W-1:0] b, input logic [`DATA_W-1:0] c, input int addr);
		commandT row;
		row = '{op: op, dst: dst[`REG_W-1:0], srcA: a, srcB: b, srcC: c,
			addr: addr[`ADDR_W-1:0]};
		rows.push_back(row);
	endtask

	////////////////////////////////////////////////////////////
	// Memory port model with random grant and response delays

	task automatic serveMemory(input int p);
		integer					s;
		int						delay;
		logic [`ADDR_W-1:0]		a;
		s = seed ^ (p + 1);
		forever begin
			@(posedge clock);
			if (arstN && memReq[p]) begin
				delay = $unsigned($random(s)) % 4;
				repeat (delay) @(posedge clock);
				memGnt[p] <= 1'b1;
				@(posedge clock);								// Lane sees the grant here
				memGnt[p] <= 1'b0;
				a = memAddr[p];
				if (memWe[p]) memory[p][a] = memWdata[p];
				else memRdata[p] <= memory[p][a];
				delay = $unsigned($random(s)) % 6;
				repeat (delay) @(posedge clock);
				memRvalid[p] <= 1'b1;
				@(posedge clock);
				memRvalid[p] <= 1'b0;
			end
		end
	endtask

	// Register file returns one credit per write-back after a random gap
	always @(posedge clock) begin
		wbCredit <= 1'b0;
		if (arstN) begin
			if (wbValid) uncredited++;
			if (uncredited > `WB_CREDITS) begin
				errors++;
				$display("more than %0d write-backs sent without a credit", `WB_CREDITS);
			end
			if (creditWait > 0) begin
				creditWait--;
			end else if (uncredited > 0) begin
				wbCredit <= 1'b1;
				uncredited--;
				creditWait = $unsigned($random(creditSeed)) % 6;
			end
		end
	end

	// Write-back monitor checks each commit against the expected queue
	always @(posedge clock) begin
		resultT exp;
		if (arstN) begin
			inFlight = inFlight + int'(cmdValid && (cmdOp != OP_NOP)) - int'(wbValid);
			if (inFlight > `LANE_CREDITS) begin
				errors++;
				$display("more than %0d commands outstanding at the lane", `LANE_CREDITS);
			end
			checkValue("cmdCredit", cmdCredit, wbValid);
			if (wbValid) begin
				commits++;
				if (expQ.size() == 0) begin
					errors++;
					$display("write-back arrived with no command outstanding");
				end else begin
					exp = expQ.pop_front();
					checkValue("wbIssueNo", wbIssueNo, exp.issueNo);
					checkValue("wbWrite", wbWrite, exp.write);
					checkValue("wbDst", wbDst, exp.dst);
					checkValue("wbData", wbData, exp.data);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Table setup, dispatch and final checks

	initial begin
		int				idx;
		int				credits;
		int				waitCycles;
		int				issue;
		resultT			exp;
		commandT		c;
		cmdValid	= 1'b0;
		cmdOp		= OP_NOP;
		cmdDst		= '0;
		cmdSrcA		= '0;
		cmdSrcB		= '0;
		cmdSrcC		= '0;
		cmdAddr		= '0;
		arstN		= 1'b0;
		for (int a = 0; a < MEM_SIZE; a++) begin
			memory[a % 2][a]	= fillWord(a);
			shadow[a]			= fillWord(a);
		end

		addRow(OP_STORE, 0, 32'hCAFE_0010, 0, 0, 'h010);			// Even port
		addRow(OP_STORE, 0, 32'h0BAD_0011, 0, 0, 'h011);			// Odd port
		addRow(OP_MULADD, 1, 3, 5, 7, 0);
		addRow(OP_MOVE, 2, 32'h1234_5678, 0, 0, 0);
		addRow(OP_LOAD, 3, 0, 0, 0, 'h010);
		addRow(OP_LOAD, 4, 0, 0, 0, 'h011);
		addRow(OP_NOP, 0, 0, 0, 0, 0);
		addRow(OP_MULADD, 5, 32'hFFFF_FFFF, 2, 5, 0);				// Wraps past DATA_W
		addRow(OP_LOAD, 6, 0, 0, 0, 'h023);						// Untouched address
		addRow(OP_MULADD, 7, 32'h0001_0000, 32'h0001_0000, 9, 0);	// Done before the load
		for (int i = 0; i < 16; i++) begin
			addRow(opcodeT'($unsigned($random(seed)) % 5), $unsigned($random(seed)) % 32,
				$random(seed), $random(seed), $random(seed), $unsigned($random(seed)) % 16);
		end

		issue = 0;
		foreach (rows[i]) begin
			c = rows[i];
			if (c.op != OP_NOP) begin
				exp.issueNo	= issue[`ISSUE_W-1:0];
				exp.dst		= c.dst;
				exp.write	= 1'b1;
				case (c.op)
					OP_MULADD:	exp.data = c.srcA * c.srcB + c.srcC;
					OP_MOVE:	exp.data = c.srcA;
					OP_LOAD:	exp.data = shadow[c.addr];
					default: begin
						exp.data		= c.srcA;					// Store echoes its data
						exp.write		= 1'b0;
						shadow[c.addr]	= c.srcA;
					end
				endcase
				expQ.push_back(exp);
				issue++;
			end
		end
		expCount	= expQ.size();
		creditSeed	= seed ^ 32'h55;
		fork
			serveMemory(0);
			serveMemory(1);
		join_none

		repeat (5) @(posedge clock);
		arstN <= 1'b1;

		credits		= `LANE_CREDITS;
		idx			= 0;
		waitCycles	= 0;
		while (idx < rows.size() && !timedOut) begin
			@(posedge clock);
			if (cmdCredit) credits++;
			if (credits > 0) begin
				cmdValid	<= 1'b1;
				cmdOp		<= rows[idx].op;
				cmdDst		<= rows[idx].dst;
				cmdSrcA		<= rows[idx].srcA;
				cmdSrcB		<= rows[idx].srcB;
				cmdSrcC		<= rows[idx].srcC;
				cmdAddr		<= rows[idx].addr;
				if (rows[idx].op != OP_NOP) credits--;
				idx++;
				waitCycles = 0;
			end else begin
				cmdValid <= 1'b0;
				waitCycles++;
				if (waitCycles > TIMEOUT) begin
					timedOut = 1'b1;
					errors++;
					$display("timeout: no issue credit came back within %0d cycles", TIMEOUT);
				end
			end
		end
		@(posedge clock);
		cmdValid <= 1'b0;

		waitCycles = 0;
		while (!timedOut && expQ.size() != 0) begin
			@(negedge clock);									// Queue is settled here
			waitCycles++;
			if (waitCycles > TIMEOUT) begin
				timedOut = 1'b1;
				errors++;
				$display("timeout: %0d write-backs still missing", expQ.size());
			end
		end

		if (!timedOut) begin
			for (int a = 0; a < MEM_SIZE; a++) begin
				checkValue("memory", memory[a % 2][a], shadow[a]);
			end
		end

		$display("errors: %0d, commits: %0d of %0d", errors, commits, expCount);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+.
vecIsaPkg.sv
vecLanePkg.sv
resultIf.sv
mulAddUnit.sv
moveBuffer.sv
ldStUnit.sv
wbArbiter.sv
execLane.sv
execLaneTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execLane testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module execLaneTb -Mdir obj_dir -o simExecLane
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simExecLane > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
	exit 0
fi
exit 1
